/* mul_unit.f */
+incdir+hw
hw/mul_pkg.sv
hw/mul_dispatch.sv
hw/mul_shift_add.sv
hw/mul_signed_lane.sv
hw/mul_collect.sv
hw/mul_unit.sv
verif/mul_unit_assert.sv
verif/mul_unit_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert \
    --top-module mul_unit_tb \
    -f mul_unit.f \
    -o Vmul_unit_tb

./obj_dir/Vmul_unit_tb 2>&1 | tee "$LOG"

if grep -qx "RESULT: PASS" "$LOG"; then
    echo "Simulation passed"
else
    echo "Simulation failed, see $LOG"
    exit 1
fi

/* verif/mul_unit_tb.sv */
`timescale 1ns/1ps
`include "mul_defs.svh"

module mul_unit_tb;

    localparam int unsigned LATENCY        = `MUL_XLEN + 3;
    localparam int unsigned TOTAL_REQS     = 5 * 5 * 4 + 200;
    localparam int unsigned TIMEOUT_CYCLES = TOTAL_REQS * (`MUL_XLEN + 4) + 200;
    localparam logic [31:0] LFSR_SEED      = 32'hea18_74e6;
    localparam logic [31:0] LFSR_TAPS      = 32'h8020_0003;

    typedef struct packed {
        mul_pkg::tag_t  tag;
        mul_pkg::xlen_t result;
        logic [31:0]    stamp;
    } pending_t;

    logic               clk;
    logic               reset;
    mul_pkg::mul_req_t  req;
    logic               req_valid;
    logic               req_ready;
    mul_pkg::mul_resp_t resp;
    logic               resp_valid;

    int unsigned        cycle = 0;
    int unsigned        errors = 0;
    int unsigned        accept_count = 0;
    int unsigned        resp_count = 0;
    int unsigned        stall_cycles = 0;
    int unsigned        max_inflight = 0;
    logic [31:0]        lfsr_state = LFSR_SEED;
    mul_pkg::tag_t      next_tag = '0;
    pending_t           pending[$];

    mul_unit UUT (
        .clk        (clk),
        .reset      (reset),
        .req        (req),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .resp       (resp),
        .resp_valid (resp_valid)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ LFSR_TAPS) : (state >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    // Extend each operand by its signedness, multiply at double width, pick a half
    function automatic mul_pkg::xlen_t ref_mul(input mul_pkg::mul_op_t op,
                                               input mul_pkg::xlen_t a,
                                               input mul_pkg::xlen_t b);
        logic            sa;
        logic            sb;
        mul_pkg::dword_t ea;
        mul_pkg::dword_t eb;
        mul_pkg::dword_t full;
        sa   = (op == `MUL_OP_MULH) || (op == `MUL_OP_MULHSU);
        sb   = (op == `MUL_OP_MULH);
        ea   = sa ? {{`MUL_XLEN{a[`MUL_XLEN-1]}}, a} : {{`MUL_XLEN{1'b0}}, a};
        eb   = sb ? {{`MUL_XLEN{b[`MUL_XLEN-1]}}, b} : {{`MUL_XLEN{1'b0}}, b};
        full = ea * eb;
        if (op == `MUL_OP_MUL) begin
            return full[`MUL_XLEN-1:0];
        end else begin
            return full[2*`MUL_XLEN-1:`MUL_XLEN];
        end
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s got=%0h exp=%0h", $time, name, got, exp);
        end
    endtask

    // Holds the request until the DUT takes it on the next rising edge
    task automatic send_request(input mul_pkg::mul_op_t op, input mul_pkg::xlen_t a,
                                input mul_pkg::xlen_t b);
        @(posedge clk);
        req       <= {op, next_tag, a, b};
        req_valid <= 1'b1;
        next_tag  = next_tag + 1'b1;
        @(negedge clk);
        while (!req_ready) begin
            @(negedge clk);
        end
    endtask

    task automatic stop_requests();
        @(posedge clk);
        req_valid <= 1'b0;
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles with %0d responses still pending",
                     cycle, pending.size());
            $display("errors=%0d accepted=%0d responses=%0d", errors, accept_count,
                     resp_count);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // Compare process, sampling at the falling edge where everything is settled
    always @(negedge clk) begin
        pending_t head;
        pending_t item;
        if (!reset) begin
            if (resp_valid) begin
                resp_count++;
                if (pending.size() == 0) begin
                    errors++;
                    $display("Response with tag %0h arrived while no request was pending",
                             resp.tag);
                end else begin
                    head = pending.pop_front();
                    check_value("resp.tag", 64'(resp.tag), 64'(head.tag));
                    check_value("resp.result", 64'(resp.result), 64'(head.result));
                    check_value("latency", 64'(cycle - head.stamp), 64'(LATENCY));
                end
            end
            if (req_valid && req_ready) begin
                item.tag    = req.tag;
                item.result = ref_mul(req.op, req.rs1, req.rs2);
                // Accepted on the coming rising edge
                item.stamp  = cycle + 1;
                pending.push_back(item);
                accept_count++;
                if (pending.size() > max_inflight) begin
                    max_inflight = pending.size();
                end
            end else if (req_valid) begin
                stall_cycles++;
            end
        end
    end

    initial begin
        mul_pkg::xlen_t    corner [5];
        mul_pkg::xlen_t    a;
        mul_pkg::xlen_t    b;
        mul_pkg::mul_op_t  op;
        logic [31:0]       r;
        reset     = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        corner[0] = '0;
        corner[1] = `MUL_XLEN'(1);
        corner[2] = '1;
        corner[3] = {1'b1, {(`MUL_XLEN-1){1'b0}}};
        corner[4] = {1'b0, {(`MUL_XLEN-1){1'b1}}};

        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_value("req_ready", 64'(req_ready), 64'd0);
        check_value("resp_valid", 64'(resp_valid), 64'd0);
        @(negedge clk);
        check_value("req_ready", 64'(req_ready), 64'd1);
        check_value("resp_valid", 64'(resp_valid), 64'd0);

        for (int o = 0; o < 4; o++) begin
            for (int i = 0; i < 5; i++) begin
                for (int j = 0; j < 5; j++) begin
                    send_request(2'(o), corner[i], corner[j]);
                end
            end
        end

        for (int n = 0; n < 200; n++) begin
            r  = random_bits(2);
            op = r[1:0];
            a  = random_bits(`MUL_XLEN);
            b  = random_bits(`MUL_XLEN);
            send_request(op, a, b);
        end
        stop_requests();

        while (pending.size() != 0) begin
            @(negedge clk);
        end
        // Give any stray response time to show up
        repeat (LATENCY + 8) @(negedge clk);

        check_value("accepted requests", 64'(accept_count), 64'(TOTAL_REQS));
        check_value("responses", 64'(resp_count), 64'(accept_count));
        check_value("max in-flight", 64'(max_inflight), 64'(`MUL_LANES));
        if (stall_cycles == 0) begin
            errors++;
            $display("req_ready never dropped while requests were waiting");
        end

        $display("errors=%0d accepted=%0d responses=%0d max_in_flight=%0d stall_cycles=%0d",
                 errors, accept_count, resp_count, max_inflight, stall_cycles);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* verif/mul_unit_assert.sv */
`timescale 1ns/1ps
`include "mul_defs.svh"

module mul_unit_assert (
    input logic clk,
    input logic reset,
    input logic req_valid,
    input logic req_ready,
    input logic resp_valid
);

    // Sampled edges from an accept to the first edge that sees its resp_valid
    localparam int RESP_DELAY = `MUL_XLEN + 4;

    int unsigned outstanding;

    // Requests accepted but not yet answered
    always_ff @(posedge clk) begin
        if (reset) begin
            outstanding <= 0;
        end else if (req_valid && req_ready && !resp_valid) begin
            outstanding <= outstanding + 32'd1;
        end else if (resp_valid && !(req_valid && req_ready)) begin
            outstanding <= outstanding - 32'd1;
        end
    end

    // Back-to-back accepts give back-to-back responses, each one a single cycle
    resp_single_pulse: assert property (
        @(posedge clk) disable iff (reset)
        resp_valid |=> !resp_valid || $past(req_valid && req_ready, RESP_DELAY)
    ) else $error("resp_valid stayed high without a second accepted request");

    ready_low_after_reset: assert property (
        @(posedge clk) $fell(reset) |-> !req_ready
    ) else $error("req_ready was high in the first cycle after reset");

    resp_needs_accept: assert property (
        @(posedge clk) disable iff (reset) resp_valid |-> (outstanding != 0)
    ) else $error("resp_valid pulsed without an earlier accepted request");

endmodule

bind mul_unit mul_unit_assert u_assert (
    .clk        (clk),
    .reset      (reset),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .resp_valid (resp_valid)
);

/* hw/mul_unit.sv */
`timescale 1ns/1ps
`include "mul_defs.svh"

module mul_unit (
    input  logic               clk,
    input  logic               reset,
    input  mul_pkg::mul_req_t  req,
    input  logic               req_valid,
    output logic               req_ready,
    output mul_pkg::mul_resp_t resp,
    output logic               resp_valid
);

    logic [`MUL_LANES-1:0] lane_ready;
    logic [`MUL_LANES-1:0] lane_start;
    logic [`MUL_LANES-1:0] lane_valid;
    mul_pkg::lane_req_t    lane_req;
    mul_pkg::lane_res_t    lane_res [`MUL_LANES];

    mul_dispatch u_dispatch (
        .clk        (clk),
        .reset      (reset),
        .req        (req),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .lane_ready (lane_ready),
        .lane_req   (lane_req),
        .lane_start (lane_start)
    );

    // All lanes share the held request and differ only in their start bit
    for (genvar g = 0; g < `MUL_LANES; g++) begin : g_lane
        mul_signed_lane u_lane (
            .clk      (clk),
            .reset    (reset),
            .start    (lane_start[g]),
            .ready    (lane_ready[g]),
            .valid    (lane_valid[g]),
            .lane_req (lane_req),
            .lane_res (lane_res[g])
        );
    end

    mul_collect u_collect (
        .clk        (clk),
        .reset      (reset),
        .lane_valid (lane_valid),
        .lane_res   (lane_res),
        .resp       (resp),
        .resp_valid (resp_valid)
    );

endmodule

/* hw/mul_collect.sv */
`timescale 1ns/1ps
`include "mul_defs.svh"

module mul_collect (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [`MUL_LANES-1:0] lane_valid,
    input  mul_pkg::lane_res_t    lane_res [`MUL_LANES],
    output mul_pkg::mul_resp_t    resp,
    output logic                  resp_valid
);

    mul_pkg::lane_res_t sel_res;
    mul_pkg::xlen_t     word;
    logic               any_valid;

    // Latency is fixed, so at most one lane finishes in a given cycle
    always_comb begin
        sel_res = lane_res[0];
        for (int i = 0; i < `MUL_LANES; i++) begin
            if (lane_valid[i]) begin
                sel_res = lane_res[i];
            end
        end
    end

    assign any_valid = |lane_valid;

    assign word = sel_res.high ? sel_res.product[2*`MUL_XLEN-1:`MUL_XLEN]
                               : sel_res.product[`MUL_XLEN-1:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= any_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (any_valid) begin
            resp.tag    <= sel_res.tag;
            resp.result <= word;
        end
    end

endmodule

/* hw/mul_signed_lane.sv */
`timescale 1ns/1ps
`include "mul_defs.svh"

module mul_signed_lane (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 start,
    output logic                 ready,
    output logic                 valid,
    input  mul_pkg::lane_req_t   lane_req,
    output mul_pkg::lane_res_t   lane_res
);

    mul_pkg::lane_state_t state;
    mul_pkg::xlen_t       a_mag;
    mul_pkg::xlen_t       b_mag;
    mul_pkg::xlen_t       a_mag_q;
    mul_pkg::xlen_t       b_mag_q;
    logic                 a_neg;
    logic                 b_neg;
    logic                 neg_q;
    logic                 high_q;
    mul_pkg::tag_t        tag_q;
    logic                 core_start_q;
    logic                 core_ready;
    logic                 core_valid;
    mul_pkg::dword_t      mag_product;

    // Only operands marked signed are treated as two's complement
    assign a_neg = lane_req.a_signed && lane_req.a[`MUL_XLEN-1];
    assign b_neg = lane_req.b_signed && lane_req.b[`MUL_XLEN-1];
    assign a_mag = a_neg ? -lane_req.a : lane_req.a;
    assign b_mag = b_neg ? -lane_req.b : lane_req.b;

    assign ready = (state == mul_pkg::LANE_IDLE) && core_ready;
    assign valid = core_valid;

    assign lane_res.high    = high_q;
    assign lane_res.tag     = tag_q;
    assign lane_res.product = neg_q ? -mag_product : mag_product;

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= mul_pkg::LANE_IDLE;
            core_start_q <= 1'b0;
        end else begin
            core_start_q <= 1'b0;
            case (state)
                mul_pkg::LANE_IDLE: begin
                    if (start) begin
                        state        <= mul_pkg::LANE_BUSY;
                        core_start_q <= 1'b1;
                    end
                end
                mul_pkg::LANE_BUSY: begin
                    if (core_valid) begin
                        state <= mul_pkg::LANE_IDLE;
                    end
                end
                default: state <= mul_pkg::LANE_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start && state == mul_pkg::LANE_IDLE) begin
            a_mag_q <= a_mag;
            b_mag_q <= b_mag;
            neg_q   <= a_neg ^ b_neg;
            high_q  <= lane_req.high;
            tag_q   <= lane_req.tag;
        end
    end

    mul_shift_add u_core (
        .clk          (clk),
        .reset        (reset),
        .start        (core_start_q),
        .ready        (core_ready),
        .valid        (core_valid),
        .multiplicand (a_mag_q),
        .multiplier   (b_mag_q),
        .product      (mag_product)
    );

endmodule

/* hw/mul_shift_add.sv */
`timescale 1ns/1ps
`include "mul_defs.svh"

module mul_shift_add (
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    output logic                ready,
    output logic                valid,
    input  mul_pkg::xlen_t      multiplicand,
    input  mul_pkg::xlen_t      multiplier,
    output mul_pkg::dword_t     product
);

    localparam int CNT_W = $clog2(`MUL_XLEN);

    mul_pkg::lane_state_t state;
    logic [CNT_W-1:0]     cnt;
    mul_pkg::dword_t      mcand_q;
    mul_pkg::xlen_t       mplier_q;

    assign ready = (state == mul_pkg::LANE_IDLE);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= mul_pkg::LANE_IDLE;
            cnt   <= '0;
            valid <= 1'b0;
        end else begin
            valid <= 1'b0;
            case (state)
                mul_pkg::LANE_IDLE: begin
                    if (start) begin
                        state <= mul_pkg::LANE_BUSY;
                        cnt   <= '0;
                    end
                end
                mul_pkg::LANE_BUSY: begin
                    cnt <= cnt + 1'b1;
                    // Last partial product goes in on this edge
                    if (cnt == CNT_W'(`MUL_XLEN - 1)) begin
                        state <= mul_pkg::LANE_IDLE;
                        valid <= 1'b1;
                    end
                end
                default: state <= mul_pkg::LANE_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start && ready) begin
            mcand_q  <= {{`MUL_XLEN{1'b0}}, multiplicand};
            mplier_q <= multiplier;
            product  <= '0;
        end else if (state == mul_pkg::LANE_BUSY) begin
            if (mplier_q[0]) begin
                product <= product + mcand_q;
            end
            mcand_q  <= mcand_q << 1;
            mplier_q <= mplier_q >> 1;
        end
    end

endmodule

/* hw/mul_dispatch.sv */
`timescale 1ns/1ps
`include "mul_defs.svh"

module mul_dispatch (
    input  logic                  clk,
    input  logic                  reset,
    input  mul_pkg::mul_req_t     req,
    input  logic                  req_valid,
    output logic                  req_ready,
    input  logic [`MUL_LANES-1:0] lane_ready,
    output mul_pkg::lane_req_t    lane_req,
    output logic [`MUL_LANES-1:0] lane_start
);

    localparam int IDX_W = $clog2(`MUL_LANES);

    logic                  active_q;
    logic [IDX_W-1:0]      ptr_q;
    logic [IDX_W-1:0]      sel;
    logic [`MUL_LANES-1:0] avail;
    logic                  accept;

    // A lane started last cycle still reports ready until it captures its operands
    assign avail     = lane_ready & ~lane_start;
    assign req_ready = active_q && (|avail);
    assign accept    = req_valid && req_ready;

    // First available lane at or after the round-robin pointer
    always_comb begin
        logic found;
        int   idx;
        found = 1'b0;
        sel   = ptr_q;
        for (int j = 0; j < `MUL_LANES; j++) begin
            idx = (int'(ptr_q) + j) % `MUL_LANES;
            if (!found && avail[idx]) begin
                found = 1'b1;
                sel   = IDX_W'(idx);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            active_q   <= 1'b0;
            ptr_q      <= '0;
            lane_start <= '0;
        end else begin
            active_q   <= 1'b1;
            lane_start <= '0;
            if (accept) begin
                lane_start[sel] <= 1'b1;
                ptr_q           <= (sel == IDX_W'(`MUL_LANES - 1)) ? '0 : sel + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            lane_req.a_signed <= (req.op == `MUL_OP_MULH) || (req.op == `MUL_OP_MULHSU);
            lane_req.b_signed <= (req.op == `MUL_OP_MULH);
            lane_req.high     <= (req.op != `MUL_OP_MUL);
            lane_req.tag      <= req.tag;
            lane_req.a        <= req.rs1;
            lane_req.b        <= req.rs2;
        end
    end

endmodule

/* hw/mul_pkg.sv */
`include "mul_defs.svh"

package mul_pkg;

    typedef logic [`MUL_XLEN-1:0]   xlen_t;
    typedef logic [2*`MUL_XLEN-1:0] dword_t;
    typedef logic [1:0]             mul_op_t;
    typedef logic [`MUL_TAG_W-1:0]  tag_t;

    typedef struct packed {
        mul_op_t op;
        tag_t    tag;
        xlen_t   rs1;
        xlen_t   rs2;
    } mul_req_t;

    // Request after op decode, as seen by a lane
    typedef struct packed {
        logic  a_signed;
        logic  b_signed;
        logic  high;
        tag_t  tag;
        xlen_t a;
        xlen_t b;
    } lane_req_t;

    typedef struct packed {
        logic   high;
        tag_t   tag;
        dword_t product;
    } lane_res_t;

    typedef struct packed {
        tag_t  tag;
        xlen_t result;
    } mul_resp_t;

    typedef enum logic {
        LANE_IDLE,
        LANE_BUSY
    } lane_state_t;

endpackage

/* hw/mul_defs.svh */
`ifndef MUL_DEFS_SVH
`define MUL_DEFS_SVH

// Operand width of the RV32 datapath
`define MUL_XLEN 32

// Number of multiplier lanes working in parallel
`define MUL_LANES 4

`define MUL_TAG_W 4

// Op codes follow the funct3 order of the M extension
`define MUL_OP_MUL    2'd0
`define MUL_OP_MULH   2'd1
`define MUL_OP_MULHSU 2'd2
`define MUL_OP_MULHU  2'd3

`endif
